// File: hw/cnn_pkg.sv
package cnn_pkg;

    //////////////////////////////////////////////////////////////////////
    // fixed field widths
    //////////////////////////////////////////////////////////////////////

    // largest kernel side, weights stored row-major as row*4+col
    localparam int MAX_K  = 4;
    localparam int N_WGT  = MAX_K * MAX_K;
    localparam int WIDX_W = $clog2(N_WGT);
    // coordinates cover sides up to 16 plus headroom
    localparam int CRD_W  = 5;
    // accumulated sum carried between stages
    localparam int SUM_W  = 20;

    //////////////////////////////////////////////////////////////////////
    // instruction
    //////////////////////////////////////////////////////////////////////

    // every other code is rejected
    typedef enum logic [3:0] {
        OP_NOP  = 4'h0,
        OP_CONV = 4'h1
    } opcode_e;

    // opcode sits in the top nibble
    typedef struct packed {
        logic [3:0]       opcode;
        logic [CRD_W-1:0] in_height;
        logic [CRD_W-1:0] in_width;
        logic [2:0]       kernel_size;
        logic [1:0]       stride;
        logic             relu_en;
        logic             pool_en;
        // must be zero
        logic [10:0]      spare;
    } instr_t;

    // latched layer setup
    typedef struct packed {
        logic [CRD_W-1:0] in_height;
        logic [CRD_W-1:0] in_width;
        logic [2:0]       kernel_size;
        logic [1:0]       stride;
        logic             relu_en;
        logic             pool_en;
    } layer_cfg_t;

    //////////////////////////////////////////////////////////////////////
    // stage payloads
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [CRD_W-1:0] out_row;
        logic [CRD_W-1:0] out_col;
        // final position of the layer
        logic             last;
    } pos_t;

    typedef struct packed {
        pos_t                    pos;
        logic signed [SUM_W-1:0] sum;
    } acc_t;

    typedef struct packed {
        logic [CRD_W-1:0]        row;
        logic [CRD_W-1:0]        col;
        logic signed [SUM_W-1:0] value;
    } px_out_t;

endpackage

// File: hw/layer_decoder.sv
module layer_decoder import cnn_pkg::*; #(
    parameter int MAX_DIM = 16
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       instr_valid,
    input  instr_t     instr,
    input  logic       busy,
    output logic       start,
    output layer_cfg_t cfg,
    output logic       illegal_instr
);

    logic blocked;
    logic conv_ok;

    // busy rises a cycle after start, so start itself also blocks
    assign blocked = busy || start;

    // field checks for a conv layer
    assign conv_ok = (instr.kernel_size >= 3'd1) && (instr.kernel_size <= 3'(MAX_K))
                  && (instr.stride != 2'd0)
                  && ({2'b00, instr.kernel_size} <= instr.in_height)
                  && ({2'b00, instr.kernel_size} <= instr.in_width)
                  && (instr.in_height <= CRD_W'(MAX_DIM))
                  && (instr.in_width <= CRD_W'(MAX_DIM))
                  && (instr.spare == '0);

    // strobes
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            start         <= 1'b0;
            illegal_instr <= 1'b0;
        end else begin
            start         <= 1'b0;
            illegal_instr <= 1'b0;
            if (instr_valid) begin
                if (blocked) begin
                    illegal_instr <= 1'b1;
                end else begin
                    case (opcode_e'(instr.opcode))
                        // nop is dropped quietly
                        OP_NOP:  ;
                        OP_CONV: begin
                            start         <= conv_ok;
                            illegal_instr <= !conv_ok;
                        end
                        default: illegal_instr <= 1'b1;
                    endcase
                end
            end
        end
    end

    // config latch, only on an accepted conv
    always_ff @(posedge clk) begin
        if (instr_valid && !blocked && (instr.opcode == OP_CONV) && conv_ok) begin
            cfg.in_height   <= instr.in_height;
            cfg.in_width    <= instr.in_width;
            cfg.kernel_size <= instr.kernel_size;
            cfg.stride      <= instr.stride;
            cfg.relu_en     <= instr.relu_en;
            cfg.pool_en     <= instr.pool_en;
        end
    end

endmodule

// File: hw/conv_sequencer.sv
module conv_sequencer import cnn_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       start,
    input  layer_cfg_t cfg,
    input  logic       acc_valid,
    input  logic       layer_done,
    output logic       pos_valid,
    output pos_t       pos,
    output logic       busy
);

    typedef enum logic [1:0] {
        IDLE,
        ISSUE,
        WAIT_MAC
    } state_e;

    state_e           state;
    logic [CRD_W-1:0] out_h;
    logic [CRD_W-1:0] out_w;
    logic [CRD_W-1:0] row_cnt;
    logic [CRD_W-1:0] col_cnt;
    logic             row_end;
    logic             col_end;

    // output side = (input side - kernel) / stride + 1
    function automatic logic [CRD_W-1:0] out_dim(input logic [CRD_W-1:0] side,
                                                 input logic [2:0]       k,
                                                 input logic [1:0]       s);
        logic [CRD_W-1:0] span;
        span = side - CRD_W'(k);
        return span / CRD_W'(s) + CRD_W'(1);
    endfunction

    assign row_end = (row_cnt == out_h - CRD_W'(1));
    assign col_end = (col_cnt == out_w - CRD_W'(1));

    // one position per ISSUE cycle
    assign pos_valid   = (state == ISSUE);
    assign pos.out_row = row_cnt;
    assign pos.out_col = col_cnt;
    assign pos.last    = row_end && col_end;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= IDLE;
            busy    <= 1'b0;
            out_h   <= '0;
            out_w   <= '0;
            row_cnt <= '0;
            col_cnt <= '0;
        end else begin
            // post stage closes the layer
            if (layer_done) begin
                busy <= 1'b0;
            end
            case (state)
                IDLE: begin
                    if (start) begin
                        out_h   <= out_dim(cfg.in_height, cfg.kernel_size, cfg.stride);
                        out_w   <= out_dim(cfg.in_width, cfg.kernel_size, cfg.stride);
                        row_cnt <= '0;
                        col_cnt <= '0;
                        busy    <= 1'b1;
                        state   <= ISSUE;
                    end
                end
                ISSUE: state <= WAIT_MAC;
                WAIT_MAC: begin
                    // wait for the window sum before the next one
                    if (acc_valid) begin
                        if (row_end && col_end) begin
                            state <= IDLE;
                        end else begin
                            state <= ISSUE;
                            if (col_end) begin
                                col_cnt <= '0;
                                row_cnt <= row_cnt + CRD_W'(1);
                            end else begin
                                col_cnt <= col_cnt + CRD_W'(1);
                            end
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// File: hw/feature_store.sv
module feature_store import cnn_pkg::*; #(
    parameter int MAX_DIM = 16,
    parameter int DATA_W  = 8
) (
    input  logic                       clk,
    input  logic                       rst,
    // image write
    input  logic                       img_we,
    input  logic [$clog2(MAX_DIM)-1:0] img_row,
    input  logic [$clog2(MAX_DIM)-1:0] img_col,
    input  logic signed [DATA_W-1:0]   img_data,
    // weight write
    input  logic                       wgt_we,
    input  logic [WIDX_W-1:0]          wgt_idx,
    input  logic signed [DATA_W-1:0]   wgt_data,
    // window read
    input  logic [$clog2(MAX_DIM)-1:0] rd_row,
    input  logic [$clog2(MAX_DIM)-1:0] rd_col,
    input  logic [WIDX_W-1:0]          rd_idx,
    output logic signed [DATA_W-1:0]   rd_pixel,
    output logic signed [DATA_W-1:0]   rd_weight
);

    logic signed [DATA_W-1:0] img_mem [MAX_DIM][MAX_DIM];
    logic signed [DATA_W-1:0] wgt_mem [N_WGT];

    // both stores start out zeroed
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int r = 0; r < MAX_DIM; r++) begin
                for (int c = 0; c < MAX_DIM; c++) begin
                    img_mem[r][c] <= '0;
                end
            end
            for (int i = 0; i < N_WGT; i++) begin
                wgt_mem[i] <= '0;
            end
        end else begin
            if (img_we) begin
                img_mem[img_row][img_col] <= img_data;
            end
            if (wgt_we) begin
                wgt_mem[wgt_idx] <= wgt_data;
            end
        end
    end

    // same-cycle reads for the mac
    assign rd_pixel  = img_mem[rd_row][rd_col];
    assign rd_weight = wgt_mem[rd_idx];

endmodule

// File: hw/window_mac.sv
module window_mac import cnn_pkg::*; #(
    parameter int MAX_DIM = 16,
    parameter int DATA_W  = 8,
    parameter int ACC_W   = 20
) (
    input  logic                       clk,
    input  logic                       rst,
    input  layer_cfg_t                 cfg,
    input  logic                       pos_valid,
    input  pos_t                       pos,
    // store read port
    output logic [$clog2(MAX_DIM)-1:0] rd_row,
    output logic [$clog2(MAX_DIM)-1:0] rd_col,
    output logic [WIDX_W-1:0]          rd_idx,
    input  logic signed [DATA_W-1:0]   rd_pixel,
    input  logic signed [DATA_W-1:0]   rd_weight,
    // window result
    output logic                       acc_valid,
    output acc_t                       acc
);

    localparam int AW = $clog2(MAX_DIM);

    logic                      running;
    logic [1:0]                tap_r;
    logic [1:0]                tap_c;
    logic                      tap_r_end;
    logic                      tap_c_end;
    logic [AW-1:0]             org_row;
    logic [AW-1:0]             org_col;
    pos_t                      pos_q;
    logic signed [2*DATA_W-1:0] prod;
    logic signed [ACC_W-1:0]   sum;

    // last tap index is k-1
    assign tap_r_end = ({1'b0, tap_r} == cfg.kernel_size - 3'd1);
    assign tap_c_end = ({1'b0, tap_c} == cfg.kernel_size - 3'd1);

    // window origin plus tap offset
    assign rd_row = org_row + AW'(tap_r);
    assign rd_col = org_col + AW'(tap_c);
    assign rd_idx = {tap_r, tap_c};

    assign prod = rd_pixel * rd_weight;

    //////////////////////////////////////////////////////////////////////
    // tap stepping
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            running   <= 1'b0;
            acc_valid <= 1'b0;
            tap_r     <= '0;
            tap_c     <= '0;
        end else begin
            // sum is complete one cycle after the last tap
            acc_valid <= running && tap_r_end && tap_c_end;
            if (pos_valid) begin
                running <= 1'b1;
                tap_r   <= '0;
                tap_c   <= '0;
            end else if (running) begin
                if (tap_c_end) begin
                    tap_c <= '0;
                    if (tap_r_end) begin
                        running <= 1'b0;
                    end else begin
                        tap_r <= tap_r + 2'd1;
                    end
                end else begin
                    tap_c <= tap_c + 2'd1;
                end
            end
        end
    end

    // origin = output coordinate * stride
    always_ff @(posedge clk) begin
        if (pos_valid) begin
            org_row <= AW'(pos.out_row * cfg.stride);
            org_col <= AW'(pos.out_col * cfg.stride);
            pos_q   <= pos;
            sum     <= '0;
        end else if (running) begin
            sum <= sum + prod;
        end
    end

    assign acc.pos = pos_q;
    assign acc.sum = SUM_W'(sum);

endmodule

// File: hw/relu_pool_stage.sv
module relu_pool_stage import cnn_pkg::*; #(
    parameter int MAX_DIM = 16,
    parameter int ACC_W   = 20
) (
    input  logic       clk,
    input  logic       rst,
    input  layer_cfg_t cfg,
    input  logic       acc_valid,
    input  acc_t       acc,
    output logic       out_valid,
    output px_out_t    out_px,
    output logic       layer_done
);

    // pooled column index width
    localparam int PW = $clog2(MAX_DIM / 2);

    logic signed [ACC_W-1:0] val;
    logic signed [ACC_W-1:0] held;
    logic signed [ACC_W-1:0] cur;
    logic [PW-1:0]           pcol;
    logic                    row_odd;
    logic                    col_odd;
    logic                    emit;

    // one running max per pooled column, covers half a row
    logic signed [ACC_W-1:0] line_buf [MAX_DIM / 2];

    // relu clamp
    assign val = (cfg.relu_en && (acc.sum < 0)) ? '0 : ACC_W'(acc.sum);

    assign row_odd = acc.pos.out_row[0];
    assign col_odd = acc.pos.out_col[0];
    assign pcol    = acc.pos.out_col[PW:1];
    assign held    = line_buf[pcol];
    assign cur     = (held > val) ? held : val;

    // pooling only lets the bottom-right of each 2x2 through
    assign emit = !cfg.pool_en || (row_odd && col_odd);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid  <= 1'b0;
            layer_done <= 1'b0;
        end else begin
            out_valid  <= acc_valid && emit;
            // fires even when the last pixel is dropped by pooling
            layer_done <= acc_valid && acc.pos.last;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // datapath
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (acc_valid) begin
            if (!cfg.pool_en) begin
                out_px.row   <= acc.pos.out_row;
                out_px.col   <= acc.pos.out_col;
                out_px.value <= SUM_W'(val);
            end else if (row_odd && col_odd) begin
                // halved coords
                out_px.row   <= {1'b0, acc.pos.out_row[CRD_W-1:1]};
                out_px.col   <= {1'b0, acc.pos.out_col[CRD_W-1:1]};
                out_px.value <= SUM_W'(cur);
            end else if (!row_odd && !col_odd) begin
                // first of a 2x2 group
                line_buf[pcol] <= val;
            end else begin
                line_buf[pcol] <= cur;
            end
        end
    end

endmodule

// File: hw/cnn_layer_top.sv
module cnn_layer_top import cnn_pkg::*; #(
    parameter int MAX_DIM = 16,
    parameter int DATA_W  = 8,
    parameter int ACC_W   = 20
) (
    input  logic                       clk,
    input  logic                       rst,
    // image load
    input  logic                       img_we,
    input  logic [$clog2(MAX_DIM)-1:0] img_row,
    input  logic [$clog2(MAX_DIM)-1:0] img_col,
    input  logic signed [DATA_W-1:0]   img_data,
    // weight load
    input  logic                       wgt_we,
    input  logic [WIDX_W-1:0]          wgt_idx,
    input  logic signed [DATA_W-1:0]   wgt_data,
    // instruction
    input  logic                       instr_valid,
    input  instr_t                     instr,
    // results
    output logic                       out_valid,
    output px_out_t                    out_px,
    output logic                       layer_done,
    output logic                       busy,
    output logic                       illegal_instr
);

    localparam int AW = $clog2(MAX_DIM);

    logic                     start;
    layer_cfg_t               cfg;
    logic                     pos_valid;
    pos_t                     pos;
    logic                     acc_valid;
    acc_t                     acc;
    logic [AW-1:0]            rd_row;
    logic [AW-1:0]            rd_col;
    logic [WIDX_W-1:0]        rd_idx;
    logic signed [DATA_W-1:0] rd_pixel;
    logic signed [DATA_W-1:0] rd_weight;

    //////////////////////////////////////////////////////////////////////
    // control
    //////////////////////////////////////////////////////////////////////

    layer_decoder #(.MAX_DIM(MAX_DIM)) u_decoder (
        .clk(clk), .rst(rst), .instr_valid(instr_valid), .instr(instr),
        .busy(busy), .start(start), .cfg(cfg), .illegal_instr(illegal_instr)
    );

    // acc_valid paces the next position
    conv_sequencer u_sequencer (
        .clk(clk), .rst(rst), .start(start), .cfg(cfg), .acc_valid(acc_valid),
        .layer_done(layer_done), .pos_valid(pos_valid), .pos(pos), .busy(busy)
    );

    //////////////////////////////////////////////////////////////////////
    // datapath
    //////////////////////////////////////////////////////////////////////

    feature_store #(.MAX_DIM(MAX_DIM), .DATA_W(DATA_W)) u_store (
        .clk(clk), .rst(rst),
        .img_we(img_we), .img_row(img_row), .img_col(img_col), .img_data(img_data),
        .wgt_we(wgt_we), .wgt_idx(wgt_idx), .wgt_data(wgt_data),
        .rd_row(rd_row), .rd_col(rd_col), .rd_idx(rd_idx),
        .rd_pixel(rd_pixel), .rd_weight(rd_weight)
    );

    window_mac #(.MAX_DIM(MAX_DIM), .DATA_W(DATA_W), .ACC_W(ACC_W)) u_mac (
        .clk(clk), .rst(rst), .cfg(cfg), .pos_valid(pos_valid), .pos(pos),
        .rd_row(rd_row), .rd_col(rd_col), .rd_idx(rd_idx),
        .rd_pixel(rd_pixel), .rd_weight(rd_weight),
        .acc_valid(acc_valid), .acc(acc)
    );

    relu_pool_stage #(.MAX_DIM(MAX_DIM), .ACC_W(ACC_W)) u_post (
        .clk(clk), .rst(rst), .cfg(cfg), .acc_valid(acc_valid), .acc(acc),
        .out_valid(out_valid), .out_px(out_px), .layer_done(layer_done)
    );

endmodule

// File: sim/cnn_ref_model.svh
`ifndef CNN_REF_MODEL_SVH
`define CNN_REF_MODEL_SVH

// reads img_ref / wgt_ref of the including testbench
// and fills its exp_row / exp_col / exp_val queues

// optional clamp at zero
function automatic int relu_ref(input int v, input bit en);
    if (en && (v < 0)) begin
        return 0;
    end
    return v;
endfunction

// plain dot product of one kxk window, origin at output coord * stride
function automatic int window_sum(input int r, input int c, input int k, input int s);
    int acc;
    acc = 0;
    for (int tr = 0; tr < k; tr++) begin
        for (int tc = 0; tc < k; tc++) begin
            acc += int'(img_ref[r * s + tr][c * s + tc]) * int'(wgt_ref[tr * 4 + tc]);
        end
    end
    return acc;
endfunction

// expected pixel stream of one layer, in emit order
function automatic void build_expected(input int h, input int w, input int k, input int s,
                                       input bit relu, input bit pool);
    int oh;
    int ow;
    int v;
    int best;
    oh = (h - k) / s + 1;
    ow = (w - k) / s + 1;
    exp_row.delete();
    exp_col.delete();
    exp_val.delete();
    if (!pool) begin
        for (int r = 0; r < oh; r++) begin
            for (int c = 0; c < ow; c++) begin
                exp_row.push_back(r);
                exp_col.push_back(c);
                exp_val.push_back(relu_ref(window_sum(r, c, k, s), relu));
            end
        end
    end else begin
        // odd trailing row / col simply never forms a full 2x2
        for (int pr = 0; pr < oh / 2; pr++) begin
            for (int pc = 0; pc < ow / 2; pc++) begin
                best = relu_ref(window_sum(2 * pr, 2 * pc, k, s), relu);
                for (int dr = 0; dr < 2; dr++) begin
                    for (int dc = 0; dc < 2; dc++) begin
                        v = relu_ref(window_sum(2 * pr + dr, 2 * pc + dc, k, s), relu);
                        if (v > best) begin
                            best = v;
                        end
                    end
                end
                exp_row.push_back(pr);
                exp_col.push_back(pc);
                exp_val.push_back(best);
            end
        end
    end
endfunction

`endif

// File: sim/tb_cnn_layer.sv
module tb_cnn_layer import cnn_pkg::*; ();

    localparam int TIMEOUT = 20000;
    localparam int SEED    = 32'h6b13_1b5f;

    logic                   clk;
    logic                   rst;
    logic                   img_we;
    logic [3:0]             img_row;
    logic [3:0]             img_col;
    logic signed [7:0]      img_data;
    logic                   wgt_we;
    logic [3:0]             wgt_idx;
    logic signed [7:0]      wgt_data;
    logic                   instr_valid;
    instr_t                 instr;
    logic                   out_valid;
    px_out_t                out_px;
    logic                   layer_done;
    logic                   busy;
    logic                   illegal_instr;

    // image and weights as loaded into the DUT
    logic signed [7:0] img_ref [16][16];
    logic signed [7:0] wgt_ref [16];

    int exp_row [$];
    int exp_col [$];
    int exp_val [$];
    int got_row [$];
    int got_col [$];
    int got_val [$];

    int error_count;
    int done_count;
    int illegal_count;
    int done_mark;
    int illegal_mark;

    `include "cnn_ref_model.svh"

    cnn_layer_top #(.MAX_DIM(16), .DATA_W(8), .ACC_W(20)) i_dut (
        .clk(clk), .rst(rst),
        .img_we(img_we), .img_row(img_row), .img_col(img_col), .img_data(img_data),
        .wgt_we(wgt_we), .wgt_idx(wgt_idx), .wgt_data(wgt_data),
        .instr_valid(instr_valid), .instr(instr),
        .out_valid(out_valid), .out_px(out_px), .layer_done(layer_done),
        .busy(busy), .illegal_instr(illegal_instr)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // output monitor, sampled mid-cycle
    always @(negedge clk) begin
        if (!rst) begin
            if (out_valid) begin
                got_row.push_back(int'(out_px.row));
                got_col.push_back(int'(out_px.col));
                got_val.push_back(int'(out_px.value));
            end
            if (layer_done) begin
                done_count++;
            end
            if (illegal_instr) begin
                illegal_count++;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus helpers
    //////////////////////////////////////////////////////////////////////

    function automatic instr_t make_instr(input logic [3:0] op, input int h, input int w,
                                          input int k, input int s,
                                          input bit relu, input bit pool);
        instr_t i;
        i             = '0;
        i.opcode      = op;
        i.in_height   = 5'(h);
        i.in_width    = 5'(w);
        i.kernel_size = 3'(k);
        i.stride      = 2'(s);
        i.relu_en     = relu;
        i.pool_en     = pool;
        return i;
    endfunction

    function automatic void fill_image(input int h, input int w);
        for (int r = 0; r < h; r++) begin
            for (int c = 0; c < w; c++) begin
                img_ref[r][c] = 8'($urandom);
            end
        end
    endfunction

    // bias shifts the 0..63 range, large bias gives mostly negative taps
    function automatic void fill_weights(input int k, input int bias);
        for (int i = 0; i < 16; i++) begin
            if ((i / 4 < k) && (i % 4 < k)) begin
                wgt_ref[i] = 8'(int'($urandom % 64) - bias);
            end else begin
                wgt_ref[i] = '0;
            end
        end
    endfunction

    task automatic wait_idle(input string name);
        int cnt;
        cnt = 0;
        @(negedge clk);
        while (busy && (cnt < TIMEOUT)) begin
            @(negedge clk);
            cnt++;
        end
        if (busy) begin
            $display("%s: timed out waiting for busy to fall", name);
            error_count++;
        end
    endtask

    // one write per cycle, image then all 16 weights
    task automatic load_data(input int h, input int w);
        for (int r = 0; r < h; r++) begin
            for (int c = 0; c < w; c++) begin
                @(posedge clk);
                img_we   <= 1'b1;
                img_row  <= 4'(r);
                img_col  <= 4'(c);
                img_data <= img_ref[r][c];
            end
        end
        for (int i = 0; i < 16; i++) begin
            @(posedge clk);
            img_we   <= 1'b0;
            wgt_we   <= 1'b1;
            wgt_idx  <= 4'(i);
            wgt_data <= wgt_ref[i];
        end
        @(posedge clk);
        wgt_we <= 1'b0;
    endtask

    task automatic send_instr(input instr_t i);
        @(posedge clk);
        instr_valid <= 1'b1;
        instr       <= i;
        @(posedge clk);
        instr_valid <= 1'b0;
    endtask

    task automatic clear_got();
        got_row.delete();
        got_col.delete();
        got_val.delete();
    endtask

    task automatic compare_pixels(input string name);
        int n;
        n = (got_val.size() < exp_val.size()) ? got_val.size() : exp_val.size();
        if (got_val.size() != exp_val.size()) begin
            $display("%s: %0d pixels expected but %0d received", name,
                     exp_val.size(), got_val.size());
            error_count++;
        end
        for (int i = 0; i < n; i++) begin
            if ((got_row[i] != exp_row[i]) || (got_col[i] != exp_col[i])
                    || (got_val[i] != exp_val[i])) begin
                $display("ERR %s: pixel %0d expected (%0d,%0d)=%0d, actual (%0d,%0d)=%0d",
                         name, i, exp_row[i], exp_col[i], exp_val[i],
                         got_row[i], got_col[i], got_val[i]);
                error_count++;
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // layer run
    //////////////////////////////////////////////////////////////////////

    task automatic start_layer(input string name, input int h, input int w, input int k,
                               input int s, input bit relu, input bit pool);
        wait_idle(name);
        load_data(h, w);
        build_expected(h, w, k, s, relu, pool);
        clear_got();
        done_mark    = done_count;
        illegal_mark = illegal_count;
        send_instr(make_instr(OP_CONV, h, w, k, s, relu, pool));
    endtask

    // n_illegal counts rejects sent on purpose during the layer
    task automatic finish_layer(input string name, input int n_illegal);
        int cnt;
        cnt = 0;
        while ((done_count == done_mark) && (cnt < TIMEOUT)) begin
            @(posedge clk);
            cnt++;
        end
        if (done_count == done_mark) begin
            $display("%s: timed out waiting for layer_done", name);
            error_count++;
        end
        // a few spare cycles to catch a second done
        repeat (4) @(posedge clk);
        if (done_count != done_mark + 1) begin
            $display("%s: layer_done fired %0d times instead of once", name,
                     done_count - done_mark);
            error_count++;
        end
        @(negedge clk);
        if (busy) begin
            $display("%s: busy still high after layer_done", name);
            error_count++;
        end
        if (illegal_count != illegal_mark + n_illegal) begin
            $display("%s: illegal_instr pulsed %0d times, %0d expected", name,
                     illegal_count - illegal_mark, n_illegal);
            error_count++;
        end
        compare_pixels(name);
    endtask

    task automatic run_layer(input string name, input int h, input int w, input int k,
                             input int s, input bit relu, input bit pool);
        start_layer(name, h, w, k, s, relu, pool);
        finish_layer(name, 0);
    endtask

    // one bad instruction while idle, nothing may start
    task automatic check_rejected(input string name, input instr_t i);
        int cnt;
        wait_idle(name);
        clear_got();
        done_mark    = done_count;
        illegal_mark = illegal_count;
        send_instr(i);
        cnt = 0;
        while ((illegal_count == illegal_mark) && (cnt < TIMEOUT)) begin
            @(posedge clk);
            cnt++;
        end
        if (illegal_count == illegal_mark) begin
            $display("%s: timed out waiting for illegal_instr", name);
            error_count++;
        end
        repeat (30) @(posedge clk);
        @(negedge clk);
        if (illegal_count != illegal_mark + 1) begin
            $display("%s: illegal_instr pulsed %0d times instead of once", name,
                     illegal_count - illegal_mark);
            error_count++;
        end
        if ((got_val.size() != 0) || (done_count != done_mark) || busy) begin
            $display("%s: rejected instruction still started a layer", name);
            error_count++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic test_identity();
        fill_image(8, 8);
        fill_weights(0, 0);
        wgt_ref[0] = 8'sd1;
        run_layer("identity_1x1", 8, 8, 1, 1, 1'b0, 1'b0);
    endtask

    task automatic test_conv3();
        fill_image(10, 12);
        fill_weights(3, 32);
        run_layer("conv_3x3", 10, 12, 3, 1, 1'b0, 1'b0);
    endtask

    task automatic test_strided();
        fill_image(9, 7);
        fill_weights(2, 32);
        run_layer("k2_s2", 9, 7, 2, 2, 1'b0, 1'b0);
        fill_image(13, 16);
        fill_weights(4, 32);
        run_layer("k4_s3", 13, 16, 4, 3, 1'b0, 1'b0);
    endtask

    task automatic test_relu();
        fill_image(8, 9);
        fill_weights(3, 56);
        run_layer("relu", 8, 9, 3, 1, 1'b1, 1'b0);
    endtask

    task automatic test_pool();
        // 9x9 conv output pools down to 4x4
        fill_image(11, 11);
        fill_weights(3, 32);
        run_layer("pool_relu", 11, 11, 3, 1, 1'b1, 1'b1);
    endtask

    task automatic test_illegal();
        int cnt;
        check_rejected("bad_opcode", make_instr(4'h7, 8, 8, 3, 1, 1'b0, 1'b0));
        check_rejected("kernel_5", make_instr(OP_CONV, 8, 8, 5, 1, 1'b0, 1'b0));
        check_rejected("stride_0", make_instr(OP_CONV, 8, 8, 3, 0, 1'b0, 1'b0));
        check_rejected("kernel_too_big", make_instr(OP_CONV, 3, 10, 4, 1, 1'b0, 1'b0));
        // second conv while the first still runs
        fill_image(6, 6);
        fill_weights(2, 32);
        start_layer("busy_reject", 6, 6, 2, 1, 1'b0, 1'b0);
        cnt = 0;
        @(negedge clk);
        while (!busy && (cnt < TIMEOUT)) begin
            @(negedge clk);
            cnt++;
        end
        if (!busy) begin
            $display("busy_reject: timed out waiting for busy to rise");
            error_count++;
        end
        send_instr(make_instr(OP_CONV, 6, 6, 2, 1, 1'b0, 1'b0));
        finish_layer("busy_reject", 1);
    endtask

    initial begin
        void'($urandom(SEED));
        rst           = 1'b1;
        img_we        = 1'b0;
        img_row       = '0;
        img_col       = '0;
        img_data      = '0;
        wgt_we        = 1'b0;
        wgt_idx       = '0;
        wgt_data      = '0;
        instr_valid   = 1'b0;
        instr         = '0;
        error_count   = 0;
        done_count    = 0;
        illegal_count = 0;
        done_mark     = 0;
        illegal_mark  = 0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        repeat (2) @(posedge clk);

        test_identity();
        test_conv3();
        test_strided();
        test_relu();
        test_pool();
        test_illegal();

        $display("errors: %0d", error_count);
        if (error_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+sim
hw/cnn_pkg.sv
hw/layer_decoder.sv
hw/conv_sequencer.sv
hw/feature_store.sv
hw/window_mac.sv
hw/relu_pool_stage.sv
hw/cnn_layer_top.sv
sim/tb_cnn_layer.sv
